// File: common/ring_macros.svh
// ring controller sizes
// word, core id, thread and requestor widths
// local queue depth and ventilation limit

`ifndef RING_MACROS_SVH
`define RING_MACROS_SVH

// packet field widths
`define RC_DATA_W       32                              // address and data words
`define RC_CORE_ID_W    8
`define RC_THREAD_W     2
`define RC_REQUESTOR_W  (`RC_CORE_ID_W + `RC_THREAD_W)  // {core id, thread}

// local source buffering
`define RC_QUEUE_DEPTH  4                               // entries per local queue

// max local packets in a row before one forced bubble
`define RC_VENT_LIMIT   3

`endif

// File: common/ringPkg.sv
// ring side types
// opcode encoding, ring packet and output slot select

`include "ring_macros.svh"

package ringPkg;

    // ==================================================================
    // opcode
    // ==================================================================
    typedef enum logic [1:0] {
        RD     = 2'b00,     // also the idle value of a bubble
        RD_RSP = 2'b01,
        WR     = 2'b10,
        WR_RSP = 2'b11
    } tOpcode;

    // ==================================================================
    // ring packet
    // ==================================================================
    // valid travels next to the packet and is not part of it
    typedef struct packed {
        logic [`RC_REQUESTOR_W-1:0] requestor;     // core id in the upper bits
        tOpcode                     opcode;
        logic [`RC_DATA_W-1:0]      address;
        logic [`RC_DATA_W-1:0]      data;
    } tRingPkt;

    // source of the next ring output slot
    typedef enum logic [1:0] {
        BUBBLE_OUT,
        RING_INPUT,
        LOCAL_OUT
    } tSlotSel;

endpackage

// File: common/corePkg.sv
// core side item types
// core request and core response as held in the local queues

`include "ring_macros.svh"

package corePkg;

    // request from the core, requestor is formed later from CoreID
    typedef struct packed {
        ringPkg::tOpcode            opcode;
        logic [`RC_DATA_W-1:0]      address;
        logic [`RC_DATA_W-1:0]      data;
        logic [`RC_THREAD_W-1:0]    threadId;
    } tCoreReq;

    // response from the core
    typedef struct packed {
        ringPkg::tOpcode            opcode;
        logic [`RC_DATA_W-1:0]      address;
        logic [`RC_DATA_W-1:0]      data;
        logic [`RC_REQUESTOR_W-1:0] requestor;  // core supplies the target requestor
    } tCoreRsp;

endpackage

// File: common/localSlotIf.sv
// local slot interface
// head valid and head packet from a local queue, pop strobe back
// from the ring channel

`timescale 1ns/100ps

interface localSlotIf;
    import ringPkg::*;

    logic    valid;     // queue holds at least one item
    tRingPkt pkt;       // head item already in ring format
    logic    pop;       // high in the LOCAL_OUT cycle only

    // queue side
    modport queue (
        output valid,
        output pkt,
        input  pop
    );

    // ring channel side
    modport channel (
        input  valid,
        input  pkt,
        output pop
    );

endinterface

// File: ringChannel/localQueue.sv
// local source queue
// circular buffer with read and write pointers and a count
// stall level while full
// head item converted to a ring packet

`timescale 1ns/100ps
`include "ring_macros.svh"

module localQueue #(
    parameter type tItem = corePkg::tCoreReq
) (
    input  logic                     QClk,
    input  logic                     rst,
    input  logic [`RC_CORE_ID_W-1:0] CoreID,
    input  logic                     wrValid,
    input  tItem                     wrItem,
    output logic                     stall,
    localSlotIf.queue                slot
);
    import ringPkg::*;
    import corePkg::*;

    localparam int PTR_W = $clog2(`RC_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`RC_QUEUE_DEPTH + 1);

    tItem             mem [`RC_QUEUE_DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;
    tItem             headItem;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`RC_QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign stall      = (count == CNT_W'(`RC_QUEUE_DEPTH));
    assign push       = wrValid && !stall;          // write while full is lost
    assign pop        = slot.pop && slot.valid;
    assign slot.valid = (count != '0);
    assign headItem   = mem[rdPtr];

    always_ff @(posedge QClk) begin
        if (push) begin
            mem[wrPtr] <= wrItem;
        end
    end

    always_ff @(posedge QClk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop)  rdPtr <= nextPtr(rdPtr);
            unique case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;    // idle or push with pop
            endcase
        end
    end

    // ==================================================================
    // head to ring packet, item kind told apart by its width
    // ==================================================================
    generate
        if ($bits(tItem) == $bits(tCoreReq)) begin : genReqHead
            tCoreReq req;
            assign req      = tCoreReq'(headItem);
            assign slot.pkt = '{requestor: {CoreID, req.threadId},  // we are the requestor
                                opcode:    req.opcode,
                                address:   req.address,
                                data:      req.data};
        end else begin : genRspHead
            tCoreRsp rsp;
            assign rsp      = tCoreRsp'(headItem);
            assign slot.pkt = '{requestor: rsp.requestor,
                                opcode:    rsp.opcode,
                                address:   rsp.address,
                                data:      rsp.data};
        end
    endgenerate

endmodule

// File: ringChannel/ringChannel.sv
// ring channel
// input slot register and core id match
// ventilation counter and slot select
// registered ring output and core delivery

`timescale 1ns/100ps
`include "ring_macros.svh"

module ringChannel (
    input  logic                     QClk,
    input  logic                     rst,
    input  logic [`RC_CORE_ID_W-1:0] CoreID,
    input  logic                     inValid,
    input  ringPkg::tRingPkt         inPkt,
    output logic                     outValid,
    output ringPkg::tRingPkt         outPkt,
    output logic                     dlvValid,
    output ringPkg::tRingPkt         dlvPkt,
    localSlotIf.channel              localSlot
);
    import ringPkg::*;

    localparam int VENT_W = $clog2(`RC_VENT_LIMIT + 1);

    logic              inValidQ;
    tRingPkt           inPktQ;
    logic              coreMatch;
    logic              mustFwd;
    logic [VENT_W-1:0] ventCnt;
    logic              ventFull;
    tSlotSel           sel;
    logic              nextValid;
    tRingPkt           nextPkt;

    // ==================================================================
    // input slot
    // ==================================================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            inValidQ <= 1'b0;
        end else begin
            inValidQ <= inValid;
        end
    end

    always_ff @(posedge QClk) begin
        inPktQ <= inPkt;    // payload, qualified by inValidQ
    end

    // our packet when the core field of the requestor is CoreID
    assign coreMatch = (inPktQ.requestor[`RC_REQUESTOR_W-1:`RC_THREAD_W] == CoreID);
    assign mustFwd   = inValidQ && !coreMatch;     // foreign traffic wins the slot

    // ==================================================================
    // ventilation and slot select
    // ==================================================================
    assign ventFull = (ventCnt == VENT_W'(`RC_VENT_LIMIT));

    always_comb begin
        if (mustFwd) begin
            sel = RING_INPUT;
        end else if (ventFull) begin
            sel = BUBBLE_OUT;               // forced gap for the other ring nodes
        end else if (localSlot.valid) begin
            sel = LOCAL_OUT;
        end else begin
            sel = BUBBLE_OUT;
        end
    end

    assign localSlot.pop = (sel == LOCAL_OUT);  // queue drops its head on this edge

    // counts local packets in a row
    always_ff @(posedge QClk) begin
        if (rst) begin
            ventCnt <= '0;
        end else begin
            unique case (sel)
                LOCAL_OUT:  ventCnt <= ventCnt + VENT_W'(1);
                BUBBLE_OUT: ventCnt <= '0;
                default:    ventCnt <= ventCnt;     // hold while forwarding
            endcase
        end
    end

    // ==================================================================
    // output slot
    // ==================================================================
    always_comb begin
        nextValid = 1'b0;
        nextPkt   = '0;         // bubble leaves every field zero
        unique case (sel)
            RING_INPUT: begin
                nextValid = 1'b1;
                nextPkt   = inPktQ;
            end
            LOCAL_OUT: begin
                nextValid = 1'b1;
                nextPkt   = localSlot.pkt;
            end
            default: begin
                nextValid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge QClk) begin
        if (rst) begin
            outValid <= 1'b0;
            dlvValid <= 1'b0;
        end else begin
            outValid <= nextValid;
            dlvValid <= inValidQ && coreMatch;  // consumed here, never forwarded
        end
    end

    always_ff @(posedge QClk) begin
        outPkt <= nextPkt;
        if (inValidQ && coreMatch) begin
            dlvPkt <= inPktQ;   // kept until the next matching packet
        end
    end

endmodule

// File: design/ringController.sv
// ring controller top
// request and response ring channels
// c2f request queue and f2c response queue
// plain port packing and unpacking

`timescale 1ns/100ps
`include "ring_macros.svh"

module ringController (
    input  logic                       QClk,
    input  logic                       rst,
    input  logic [`RC_CORE_ID_W-1:0]   CoreID,
    // request ring in
    input  logic                       RingReqInValid,
    input  logic [`RC_REQUESTOR_W-1:0] RingReqInRequestor,
    input  ringPkg::tOpcode            RingReqInOpcode,
    input  logic [`RC_DATA_W-1:0]      RingReqInAddress,
    input  logic [`RC_DATA_W-1:0]      RingReqInData,
    // response ring in
    input  logic                       RingRspInValid,
    input  logic [`RC_REQUESTOR_W-1:0] RingRspInRequestor,
    input  ringPkg::tOpcode            RingRspInOpcode,
    input  logic [`RC_DATA_W-1:0]      RingRspInAddress,
    input  logic [`RC_DATA_W-1:0]      RingRspInData,
    // request ring out
    output logic                       RingReqOutValid,
    output logic [`RC_REQUESTOR_W-1:0] RingReqOutRequestor,
    output ringPkg::tOpcode            RingReqOutOpcode,
    output logic [`RC_DATA_W-1:0]      RingReqOutAddress,
    output logic [`RC_DATA_W-1:0]      RingReqOutData,
    // response ring out
    output logic                       RingRspOutValid,
    output logic [`RC_REQUESTOR_W-1:0] RingRspOutRequestor,
    output ringPkg::tOpcode            RingRspOutOpcode,
    output logic [`RC_DATA_W-1:0]      RingRspOutAddress,
    output logic [`RC_DATA_W-1:0]      RingRspOutData,
    // core requests to the ring
    input  logic                       C2F_ReqValid,
    input  ringPkg::tOpcode            C2F_ReqOpcode,
    input  logic [`RC_DATA_W-1:0]      C2F_ReqAddress,
    input  logic [`RC_DATA_W-1:0]      C2F_ReqData,
    input  logic [`RC_THREAD_W-1:0]    C2F_ReqThreadID,
    output logic                       C2F_ReqStall,
    // core responses to the ring
    input  logic                       F2C_RspValid,
    input  ringPkg::tOpcode            F2C_RspOpcode,
    input  logic [`RC_DATA_W-1:0]      F2C_RspAddress,
    input  logic [`RC_DATA_W-1:0]      F2C_RspData,
    input  logic [`RC_REQUESTOR_W-1:0] F2C_RspRequestor,
    output logic                       F2C_RspStall,
    // requests delivered to the core
    output logic                       F2C_ReqValid,
    output ringPkg::tOpcode            F2C_ReqOpcode,
    output logic [`RC_DATA_W-1:0]      F2C_ReqAddress,
    output logic [`RC_DATA_W-1:0]      F2C_ReqData,
    // responses delivered to the core
    output logic                       C2F_RspValid,
    output ringPkg::tOpcode            C2F_RspOpcode,
    output logic [`RC_DATA_W-1:0]      C2F_RspData,
    output logic [`RC_THREAD_W-1:0]    C2F_RspThreadID
);
    import ringPkg::*;
    import corePkg::*;

    tRingPkt reqInPkt;
    tRingPkt rspInPkt;
    tRingPkt reqOutPkt;
    tRingPkt rspOutPkt;
    tRingPkt reqDlvPkt;
    tRingPkt rspDlvPkt;
    tCoreReq c2fItem;
    tCoreRsp f2cItem;

    localSlotIf reqSlot ();     // c2fQueue to reqChannel
    localSlotIf rspSlot ();     // f2cQueue to rspChannel

    // ==================================================================
    // port packing
    // ==================================================================
    assign reqInPkt = '{RingReqInRequestor, RingReqInOpcode, RingReqInAddress, RingReqInData};
    assign rspInPkt = '{RingRspInRequestor, RingRspInOpcode, RingRspInAddress, RingRspInData};
    assign c2fItem  = '{C2F_ReqOpcode, C2F_ReqAddress, C2F_ReqData, C2F_ReqThreadID};
    assign f2cItem  = '{F2C_RspOpcode, F2C_RspAddress, F2C_RspData, F2C_RspRequestor};

    assign {RingReqOutRequestor, RingReqOutOpcode, RingReqOutAddress, RingReqOutData} = reqOutPkt;
    assign {RingRspOutRequestor, RingRspOutOpcode, RingRspOutAddress, RingRspOutData} = rspOutPkt;

    assign F2C_ReqOpcode   = reqDlvPkt.opcode;
    assign F2C_ReqAddress  = reqDlvPkt.address;
    assign F2C_ReqData     = reqDlvPkt.data;
    assign C2F_RspOpcode   = rspDlvPkt.opcode;
    assign C2F_RspData     = rspDlvPkt.data;
    assign C2F_RspThreadID = rspDlvPkt.requestor[`RC_THREAD_W-1:0];   // thread of our request

    // ==================================================================
    // request side
    // ==================================================================
    localQueue #(.tItem(tCoreReq)) c2fQueue (
        .QClk(QClk), .rst(rst), .CoreID(CoreID),
        .wrValid(C2F_ReqValid), .wrItem(c2fItem), .stall(C2F_ReqStall), .slot(reqSlot)
    );

    ringChannel reqChannel (
        .QClk(QClk), .rst(rst), .CoreID(CoreID),
        .inValid(RingReqInValid), .inPkt(reqInPkt),
        .outValid(RingReqOutValid), .outPkt(reqOutPkt),
        .dlvValid(F2C_ReqValid), .dlvPkt(reqDlvPkt), .localSlot(reqSlot)
    );

    // response side
    localQueue #(.tItem(tCoreRsp)) f2cQueue (
        .QClk(QClk), .rst(rst), .CoreID(CoreID),
        .wrValid(F2C_RspValid), .wrItem(f2cItem), .stall(F2C_RspStall), .slot(rspSlot)
    );

    ringChannel rspChannel (
        .QClk(QClk), .rst(rst), .CoreID(CoreID),
        .inValid(RingRspInValid), .inPkt(rspInPkt),
        .outValid(RingRspOutValid), .outPkt(rspOutPkt),
        .dlvValid(C2F_RspValid), .dlvPkt(rspDlvPkt), .localSlot(rspSlot)
    );

endmodule

// File: tests/ringController_properties.sv
// concurrent checks on one ring channel
// ventilation gap seen on the ring output
// popped head sent on the ring, own packets delivered and never forwarded
// bound into every ringChannel instance

`timescale 1ns/100ps
`include "ring_macros.svh"

module ringChannelProperties (
    input logic             QClk,
    input logic             rst,
    input logic             pop,
    input logic             headValid,
    input ringPkg::tRingPkt headPkt,
    input logic             inValidQ,
    input ringPkg::tRingPkt inPktQ,
    input logic             coreMatch,
    input logic             outValid,
    input ringPkg::tRingPkt outPkt,
    input logic             dlvValid,
    input ringPkg::tRingPkt dlvPkt
);
    import ringPkg::*;

    logic       fwd;        // foreign slot in the input register
    logic [3:0] localRun;   // pops since the last bubble

    assign fwd = inValidQ && !coreMatch;

    always_ff @(posedge QClk) begin
        if (rst) begin
            localRun <= '0;
        end else if (pop) begin
            localRun <= localRun + 4'd1;
        end else if (!fwd) begin
            localRun <= '0;         // bubble slot
        end
    end

    // a full run leaves only forwarding or a bubble on the ring
    ventGap: assert property (@(posedge QClk) disable iff (rst)
        (localRun == 4'(`RC_VENT_LIMIT) && !fwd) |=> !outValid)
        else $error("local slot after a full ventilation run");

    // popped head must be the next ring slot
    popHasHead: assert property (@(posedge QClk) disable iff (rst)
        pop |=> ($past(headValid) && outValid && outPkt == $past(headPkt)))
        else $error("pop without a valid queue head or popped packet not sent");

    ownNotForwarded: assert property (@(posedge QClk) disable iff (rst)
        (inValidQ && coreMatch) |=>
            (dlvValid && dlvPkt == $past(inPktQ)
             && (!outValid || outPkt == $past(headPkt))))
        else $error("packet for this core not delivered or forwarded on the ring");

endmodule

bind ringChannel ringChannelProperties channelProps (
    .QClk(QClk), .rst(rst),
    .pop(localSlot.pop), .headValid(localSlot.valid), .headPkt(localSlot.pkt),
    .inValidQ(inValidQ), .inPktQ(inPktQ), .coreMatch(coreMatch),
    .outValid(outValid), .outPkt(outPkt),
    .dlvValid(dlvValid), .dlvPkt(dlvPkt)
);

// File: tests/tbRingController.sv
// ring controller testbench
// clock, reset and LFSR stimulus on both rings and both core sources
// cycle model of the two ring channels, output checks and verdict

`timescale 1ns/100ps
`include "ring_macros.svh"

module tbRingController;
    import ringPkg::*;
    import corePkg::*;

    logic                       QClk;
    logic                       rst;
    logic [`RC_CORE_ID_W-1:0]   coreId;
    logic                       reqInV, rspInV;         // ring input slots
    tRingPkt                    reqIn, rspIn;
    logic                       c2fInV, f2cInV;         // core writes
    tCoreReq                    c2fIn;
    tCoreRsp                    f2cIn;
    logic                       reqOutV, rspOutV, f2cReqV, c2fRspV, c2fStall, f2cStall;
    logic [`RC_REQUESTOR_W-1:0] reqOutReq, rspOutReq;
    tOpcode                     reqOutOp, rspOutOp, f2cReqOp, c2fRspOp;
    logic [`RC_DATA_W-1:0]      reqOutAddr, rspOutAddr, reqOutData, rspOutData;
    logic [`RC_DATA_W-1:0]      f2cReqAddr, f2cReqData, c2fRspData;
    logic [`RC_THREAD_W-1:0]    c2fRspThread;

    // model state, index 0 is the request ring, 1 the response ring
    logic    mInV [2];          // slot held in the input register
    tRingPkt mInPkt [2];
    int      mVent [2];         // local slots in a row
    tRingPkt localQ [2][$];     // expected local packets in issue order
    logic    expOutV [2];
    tRingPkt expOutPkt [2];
    logic    expDlvV [2];
    tRingPkt expDlvPkt [2];

    logic [31:0] lfsr;
    int          ringMode;      // 0 idle, 1 random, 2 foreign every cycle
    int          coreMode;      // 0 none, 1 random, 2 every cycle while not stalled
    int          cycle, checks, errors, timeouts;

    ringController UUT (
        .QClk(QClk), .rst(rst), .CoreID(coreId),
        .RingReqInValid(reqInV), .RingReqInRequestor(reqIn.requestor),
        .RingReqInOpcode(reqIn.opcode), .RingReqInAddress(reqIn.address),
        .RingReqInData(reqIn.data),
        .RingRspInValid(rspInV), .RingRspInRequestor(rspIn.requestor),
        .RingRspInOpcode(rspIn.opcode), .RingRspInAddress(rspIn.address),
        .RingRspInData(rspIn.data),
        .RingReqOutValid(reqOutV), .RingReqOutRequestor(reqOutReq),
        .RingReqOutOpcode(reqOutOp), .RingReqOutAddress(reqOutAddr),
        .RingReqOutData(reqOutData),
        .RingRspOutValid(rspOutV), .RingRspOutRequestor(rspOutReq),
        .RingRspOutOpcode(rspOutOp), .RingRspOutAddress(rspOutAddr),
        .RingRspOutData(rspOutData),
        .C2F_ReqValid(c2fInV), .C2F_ReqOpcode(c2fIn.opcode), .C2F_ReqAddress(c2fIn.address),
        .C2F_ReqData(c2fIn.data), .C2F_ReqThreadID(c2fIn.threadId), .C2F_ReqStall(c2fStall),
        .F2C_RspValid(f2cInV), .F2C_RspOpcode(f2cIn.opcode), .F2C_RspAddress(f2cIn.address),
        .F2C_RspData(f2cIn.data), .F2C_RspRequestor(f2cIn.requestor), .F2C_RspStall(f2cStall),
        .F2C_ReqValid(f2cReqV), .F2C_ReqOpcode(f2cReqOp), .F2C_ReqAddress(f2cReqAddr),
        .F2C_ReqData(f2cReqData),
        .C2F_RspValid(c2fRspV), .C2F_RspOpcode(c2fRspOp), .C2F_RspData(c2fRspData),
        .C2F_RspThreadID(c2fRspThread)
    );

    initial begin
        QClk = 1'b0;
        forever #50 QClk = ~QClk;   // 100 ns period
    end

    // ==================================================================
    // stimulus
    // ==================================================================
    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] nextBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic makeSlot(input int mode, output logic v, output tRingPkt p);
        logic                     own;
        logic [`RC_CORE_ID_W-1:0] id;
        v   = (mode == 2);
        own = 1'b0;
        p   = '0;
        if (mode == 1) begin
            v   = (nextBits(2) != 0);   // 3 of 4 slots busy
            own = (nextBits(2) == 0);   // 1 of 4 addressed to us
        end
        if (v) begin
            id = `RC_CORE_ID_W'(nextBits(`RC_CORE_ID_W));
            if (id == coreId) id[0] = ~id[0];  // keep foreign ids foreign
            if (own) id = coreId;
            p.requestor = {id, `RC_THREAD_W'(nextBits(`RC_THREAD_W))};
            p.opcode    = tOpcode'(2'(nextBits(2)));
            p.address   = nextBits(`RC_DATA_W);
            p.data      = nextBits(`RC_DATA_W);
        end
    endtask

    task automatic driveInputs();
        makeSlot(ringMode, reqInV, reqIn);
        makeSlot(ringMode, rspInV, rspIn);
        c2fInV = 1'b0;
        f2cInV = 1'b0;
        if (coreMode != 0 && !c2fStall) begin   // never write into a full queue
            c2fInV         = (coreMode == 2) || (nextBits(1) != 0);
            c2fIn.opcode   = tOpcode'(2'(nextBits(2)));
            c2fIn.address  = nextBits(`RC_DATA_W);
            c2fIn.data     = nextBits(`RC_DATA_W);
            c2fIn.threadId = `RC_THREAD_W'(nextBits(`RC_THREAD_W));
        end
        if (coreMode != 0 && !f2cStall) begin
            f2cInV          = (coreMode == 2) || (nextBits(1) != 0);
            f2cIn.opcode    = tOpcode'(2'(nextBits(2)));
            f2cIn.address   = nextBits(`RC_DATA_W);
            f2cIn.data      = nextBits(`RC_DATA_W);
            f2cIn.requestor = {`RC_CORE_ID_W'(nextBits(`RC_CORE_ID_W)),
                               `RC_THREAD_W'(nextBits(`RC_THREAD_W))};
        end
    endtask

    // ==================================================================
    // model and checks
    // ==================================================================
    task automatic stepChannel(input int ch, input logic newV, input tRingPkt newPkt,
                               input logic wrV, input tRingPkt wrPkt);
        logic own;
        logic full;
        own  = (mInPkt[ch].requestor[`RC_REQUESTOR_W-1:`RC_THREAD_W] == coreId);
        full = (localQ[ch].size() == `RC_QUEUE_DEPTH);     // stall before this edge
        expDlvV[ch] = mInV[ch] && own;
        if (expDlvV[ch]) expDlvPkt[ch] = mInPkt[ch];
        expOutV[ch]   = 1'b1;
        expOutPkt[ch] = '0;
        if (mInV[ch] && !own) begin
            expOutPkt[ch] = mInPkt[ch];                    // foreign slot has priority
        end else if (mVent[ch] == `RC_VENT_LIMIT) begin
            expOutV[ch] = 1'b0;                            // forced bubble
            mVent[ch]   = 0;
        end else if (localQ[ch].size() != 0) begin
            expOutPkt[ch] = localQ[ch].pop_front();
            mVent[ch]++;
        end else begin
            expOutV[ch] = 1'b0;
            mVent[ch]   = 0;
        end
        if (wrV && !full) localQ[ch].push_back(wrPkt);
        mInV[ch]   = newV;
        mInPkt[ch] = newPkt;
    endtask

    task automatic stepModel();
        tRingPkt reqLocal;
        tRingPkt rspLocal;
        reqLocal = {coreId, c2fIn.threadId, c2fIn.opcode, c2fIn.address, c2fIn.data};
        rspLocal = {f2cIn.requestor, f2cIn.opcode, f2cIn.address, f2cIn.data};
        stepChannel(0, reqInV, reqIn, c2fInV, reqLocal);
        stepChannel(1, rspInV, rspIn, f2cInV, rspLocal);
    endtask

    task automatic checkValue(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s cycle %0d: expected %h, actual %h",
                     name, cycle, expected, actual);
        end
    endtask

    task automatic checkOutputs();
        checkValue("reqRingValid", 128'(expOutV[0]), 128'(reqOutV));
        checkValue("reqRingPkt", 128'(expOutPkt[0]),
                   128'({reqOutReq, reqOutOp, reqOutAddr, reqOutData}));
        checkValue("rspRingValid", 128'(expOutV[1]), 128'(rspOutV));
        checkValue("rspRingPkt", 128'(expOutPkt[1]),
                   128'({rspOutReq, rspOutOp, rspOutAddr, rspOutData}));
        checkValue("f2cReqValid", 128'(expDlvV[0]), 128'(f2cReqV));
        if (expDlvV[0] && f2cReqV) begin
            checkValue("f2cReqFields",
                       128'({expDlvPkt[0].opcode, expDlvPkt[0].address, expDlvPkt[0].data}),
                       128'({f2cReqOp, f2cReqAddr, f2cReqData}));
        end
        checkValue("c2fRspValid", 128'(expDlvV[1]), 128'(c2fRspV));
        if (expDlvV[1] && c2fRspV) begin
            checkValue("c2fRspFields", 128'({expDlvPkt[1].opcode, expDlvPkt[1].data,
                       expDlvPkt[1].requestor[`RC_THREAD_W-1:0]}),
                       128'({c2fRspOp, c2fRspData, c2fRspThread}));
        end
        checkValue("c2fReqStall", 128'(localQ[0].size() == `RC_QUEUE_DEPTH), 128'(c2fStall));
        checkValue("f2cRspStall", 128'(localQ[1].size() == `RC_QUEUE_DEPTH), 128'(f2cStall));
    endtask

    // outputs are registered, so the falling edge sees them settled
    task automatic tick();
        @(negedge QClk);
        cycle++;
        checkOutputs();
        driveInputs();
        stepModel();
    endtask

    task automatic waitForStall(input logic level);
        int n;
        n = 0;
        while (!(c2fStall == level && f2cStall == level) && n < 20) begin
            tick();
            n++;
        end
        if (c2fStall != level || f2cStall != level) begin
            timeouts++;
            $display("timeout: stall levels did not both reach %0b", level);
        end
    endtask

    task automatic waitForDrain();
        int n;
        n = 0;
        while ((localQ[0].size() != 0 || localQ[1].size() != 0) && n < 40) begin
            tick();
            n++;
        end
        if (localQ[0].size() != 0 || localQ[1].size() != 0) begin
            timeouts++;
            $display("timeout: local queues did not drain");
        end
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================
    initial begin
        int   waitCnt;
        int   reqBubbles;
        int   rspBubbles;
        logic seenReq;
        logic seenRsp;
        lfsr     = 32'h2532_71e2;
        coreId   = 8'h5A;
        rst      = 1'b1;
        {reqInV, rspInV, c2fInV, f2cInV} = '0;
        {reqIn, rspIn, c2fIn, f2cIn}     = '0;
        {ringMode, coreMode, cycle, checks, errors, timeouts} = '0;
        for (int ch = 0; ch < 2; ch++) begin
            mInV[ch]      = 1'b0;
            mInPkt[ch]    = '0;
            mVent[ch]     = 0;
            expOutV[ch]   = 1'b0;
            expOutPkt[ch] = '0;
            expDlvV[ch]   = 1'b0;
            expDlvPkt[ch] = '0;
        end
        repeat (3) @(posedge QClk);
        @(negedge QClk);
        checkOutputs();         // everything idle out of reset
        rst = 1'b0;
        stepModel();

        ringMode = 1;           // mixed traffic on both rings and both queues
        coreMode = 1;
        repeat (400) tick();

        // idle ring with full queues, three locals then a bubble
        ringMode = 0;
        coreMode = 2;
        {waitCnt, seenReq, seenRsp} = '0;
        while (!(seenReq && seenRsp) && waitCnt < 30) begin
            tick();
            seenReq = seenReq | c2fStall;
            seenRsp = seenRsp | f2cStall;
            waitCnt++;
        end
        if (!(seenReq && seenRsp)) begin
            timeouts++;
            $display("timeout: local queues never filled with the ring idle");
        end
        {reqBubbles, rspBubbles} = '0;
        repeat (32) begin
            tick();
            if (!reqOutV) reqBubbles++;
            if (!rspOutV) rspBubbles++;
        end
        checkValue("reqVentBubbles", 128'(32 / (`RC_VENT_LIMIT + 1)), 128'(reqBubbles));
        checkValue("rspVentBubbles", 128'(32 / (`RC_VENT_LIMIT + 1)), 128'(rspBubbles));

        // fill behind continuous foreign traffic, then release
        coreMode = 0;
        waitForDrain();
        ringMode = 2;
        coreMode = 2;
        waitForStall(1'b1);
        repeat (4) tick();      // stall holds while the ring stays busy
        ringMode = 0;
        coreMode = 0;
        waitForStall(1'b0);
        waitForDrain();
        repeat (4) tick();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+common
common/ringPkg.sv
common/corePkg.sv
common/localSlotIf.sv
ringChannel/localQueue.sv
ringChannel/ringChannel.sv
design/ringController.sv
tests/ringController_properties.sv
tests/tbRingController.sv

// File: run.sh
#!/bin/sh
# compile the ring controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbRingController -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

simOut=$(./obj_dir/VtbRingController)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
